// File: design/alu_macros.svh
/* ALU build constants */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data path width of the full ALU
`define ALU_WIDTH 16

// Number of 4-bit slices in the data path
// Must equal ALU_WIDTH / 4
`define ALU_SLICES 4

// Command queue entries
`define QUEUE_DEPTH 4

`endif

// File: design/aluPkg.sv
/* ALU command types */
`include "alu_macros.svh"

package aluPkg;

  // Function select of the 181-style slice table
  typedef logic [3:0] aluSelect;

  // Arithmetic uses the carry, logic ignores it
  typedef enum logic {
    modeArith = 1'b0,
    modeLogic = 1'b1
  } aluMode;

  // Select codes referred to by name
  localparam aluSelect selAdd       = 4'b1001;  // A plus B, arithmetic
  localparam aluSelect selSubtract  = 4'b0110;  // A minus B minus 1, arithmetic
  localparam aluSelect selMinusOne  = 4'b0011;  // All ones, arithmetic
  localparam aluSelect selShiftLeft = 4'b1100;  // A plus A, arithmetic
  localparam aluSelect selPassA     = 4'b1111;  // F equals A, logic

  // One queued request
  // carryIn is active low
  typedef struct packed {
    aluSelect               select;
    aluMode                 mode;
    logic                   carryIn;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;
  } aluCommand;

  // One computed answer, carryOut active low
  typedef struct packed {
    logic [`ALU_WIDTH-1:0]  f;
    logic                   carryOut;
    logic                   equal;
  } aluResult;

endpackage

// File: design/aluSlice.sv
/* 4-bit ALU slice */
module aluSlice (
  input  aluPkg::aluSelect  select,
  input  aluPkg::aluMode    mode,
  input  logic              carryIn,
  input  logic [3:0]        a,
  input  logic [3:0]        b,
  output logic [3:0]        f,
  output logic              carryOut,
  output logic              propagateN,
  output logic              generateN,
  output logic              equal
);
  import aluPkg::*;

  // Per-bit terms as the 181 gates form them
  logic [3:0] bitProp;
  logic [3:0] bitGen;
  // Arithmetic operand pair and 5-bit sum
  logic [3:0] opX;
  logic [3:0] opY;
  logic [4:0] sum;
  // Group terms for the lookahead pins
  logic       groupKill;
  logic       chainRun;

  // Propagate selects among A, A or B, A or not B
  // Generate is the second arithmetic operand
  assign bitProp = a | (b & {4{select[0]}}) | (~b & {4{select[1]}});
  assign bitGen  = (a & ~b & {4{select[2]}}) | (a & b & {4{select[3]}});

  // Arithmetic operands per select code
  always_comb
  begin
    case (select)
      4'b0000:      begin opX = a;            opY = 4'b0000;    end  // A
      4'b0001:      begin opX = a | b;        opY = 4'b0000;    end  // A or B
      4'b0010:      begin opX = a | ~b;       opY = 4'b0000;    end  // A or not B
      selMinusOne:  begin opX = 4'b1111;      opY = 4'b0000;    end
      4'b0100:      begin opX = a;            opY = a & ~b;     end
      4'b0101:      begin opX = a | b;        opY = a & ~b;     end
      selSubtract:  begin opX = a;            opY = ~b;         end
      4'b0111:      begin opX = a & ~b;       opY = 4'b1111;    end  // minus 1
      4'b1000:      begin opX = a;            opY = a & b;      end
      selAdd:       begin opX = a;            opY = b;          end
      4'b1010:      begin opX = a | ~b;       opY = a & b;      end
      4'b1011:      begin opX = a & b;        opY = 4'b1111;    end
      selShiftLeft: begin opX = a;            opY = a;          end
      4'b1101:      begin opX = a;            opY = a | b;      end
      4'b1110:      begin opX = a;            opY = a | ~b;     end
      default:      begin opX = a;            opY = 4'b1111;    end  // A minus 1
    endcase
  end

  // Carry in is active low, so its inverse is added
  assign sum = {1'b0, opX} + {1'b0, opY} + {4'b0000, ~carryIn};

  // Group terms for the lookahead
  // Running product walks down from the top bit
  always_comb
  begin
    groupKill = 1'b0;
    chainRun  = 1'b1;
    for (int i = 3; i >= 0; i--)
    begin
      groupKill = groupKill | (chainRun & ~bitProp[i]);
      chainRun  = chainRun & ~bitGen[i];
    end
  end

  // Result word and carry per mode
  always_comb
  begin
    if (mode == modeArith)
    begin
      f        = sum[3:0];
      carryOut = ~sum[4];
    end
    else
    begin
      case (select)
        4'b0000:  f = ~a;
        4'b0001:  f = ~(a | b);
        4'b0010:  f = ~a & b;
        4'b0011:  f = 4'b0000;
        4'b0100:  f = ~(a & b);
        4'b0101:  f = ~b;
        4'b0110:  f = a ^ b;
        4'b0111:  f = a & ~b;
        4'b1000:  f = ~a | b;
        4'b1001:  f = ~(a ^ b);
        4'b1010:  f = b;
        4'b1011:  f = a & b;
        4'b1100:  f = 4'b1111;
        4'b1101:  f = a | ~b;
        4'b1110:  f = a | b;
        selPassA: f = a;
        default:  f = a;
      endcase
      // Gate-level carry, still active low
      carryOut = (carryIn & chainRun) | groupKill;
    end
  end

  // Lookahead pins in the 181 pin sense
  assign propagateN = ~chainRun;
  assign generateN  = ~groupKill;

  // All ones on F, a compare flag after subtract
  assign equal = &f;

endmodule

// File: design/carryLookahead.sv
/* Slice carry lookahead */
`include "alu_macros.svh"

module carryLookahead (
  input  logic                    carryIn,
  input  logic [`ALU_SLICES-1:0]  propagateN,
  input  logic [`ALU_SLICES-1:0]  generateN,
  output logic [`ALU_SLICES-1:1]  sliceCarry
);

  // Sum-of-products accumulators
  logic carryTerm;
  logic runTerm;

  // Carries stay active low, as at the slice pins
  // Into slice k: g[k-1] | p[k-1]g[k-2] | ... | p[k-1..0]cin
  always_comb
  begin
    carryTerm = 1'b0;
    runTerm   = 1'b1;
    for (int k = 1; k < `ALU_SLICES; k++)
    begin
      carryTerm = 1'b0;
      runTerm   = 1'b1;
      for (int j = k - 1; j >= 0; j--)
      begin
        carryTerm = carryTerm | (runTerm & ~generateN[j]);
        runTerm   = runTerm & ~propagateN[j];
      end
      // Incoming carry reaches slice k only through every lower slice
      sliceCarry[k] = carryTerm | (runTerm & carryIn);
    end
  end

endmodule

// File: design/wideAlu.sv
/* 16-bit ALU */
`include "alu_macros.svh"

module wideAlu (
  input  aluPkg::aluSelect        select,
  input  aluPkg::aluMode          mode,
  input  logic                    carryIn,
  input  logic [`ALU_WIDTH-1:0]   a,
  input  logic [`ALU_WIDTH-1:0]   b,
  output logic [`ALU_WIDTH-1:0]   f,
  output logic                    carryOut,
  output logic                    equal
);

  // Carry into each slice, bit 0 from outside
  logic [`ALU_SLICES-1:0] sliceCarryIn;
  logic [`ALU_SLICES-1:0] sliceCarryOut;
  logic [`ALU_SLICES-1:0] slicePropagateN;
  logic [`ALU_SLICES-1:0] sliceGenerateN;
  logic [`ALU_SLICES-1:0] sliceEqual;

  // Upper carries come from the lookahead, not the ripple
  carryLookahead lookahead (
    .carryIn    (carryIn),
    .propagateN (slicePropagateN),
    .generateN  (sliceGenerateN),
    .sliceCarry (sliceCarryIn[`ALU_SLICES-1:1])
  );

  assign sliceCarryIn[0] = carryIn;

  for (genvar k = 0; k < `ALU_SLICES; k++)
  begin : gSlice
    aluSlice slice (
      .select     (select),
      .mode       (mode),
      .carryIn    (sliceCarryIn[k]),
      .a          (a[4*k +: 4]),
      .b          (b[4*k +: 4]),
      .f          (f[4*k +: 4]),
      .carryOut   (sliceCarryOut[k]),
      .propagateN (slicePropagateN[k]),
      .generateN  (sliceGenerateN[k]),
      .equal      (sliceEqual[k])
    );
  end

  // Top slice carry is the word carry
  assign carryOut = sliceCarryOut[`ALU_SLICES-1];
  assign equal    = &sliceEqual;

endmodule

// File: design/requestReceiver.sv
/* Command handshake receiver */
`include "alu_macros.svh"

module requestReceiver (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmdReq,
  input  aluPkg::aluSelect        cmdSelect,
  input  aluPkg::aluMode          cmdMode,
  input  logic                    cmdCarryIn,
  input  logic [`ALU_WIDTH-1:0]   cmdA,
  input  logic [`ALU_WIDTH-1:0]   cmdB,
  input  logic                    full,
  output logic                    cmdAck,
  output logic                    pushValid,
  output aluPkg::aluCommand       pushData
);
  import aluPkg::*;

  typedef enum logic {
    waitRequest = 1'b0,
    waitRelease = 1'b1
  } receiverState;

  receiverState state;

  // Write once per request, held off while the queue is full
  assign pushValid = (state == waitRequest) && cmdReq && !full;

  // Fields are stable while cmdReq is high
  assign pushData = '{select: cmdSelect, mode: cmdMode, carryIn: cmdCarryIn,
                      a: cmdA, b: cmdB};

  // Ack tracks the release phase
  assign cmdAck = (state == waitRelease);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= waitRequest;
    end
    else
    begin
      case (state)
        waitRequest:
          if (pushValid)
            state <= waitRelease;
        // Drop ack the cycle after req is seen low
        default:
          if (!cmdReq)
            state <= waitRequest;
      endcase
    end
  end

endmodule

// File: design/commandQueue.sv
/* Command FIFO */
`include "alu_macros.svh"

module commandQueue (
  input  logic                clk,
  input  logic                reset,
  input  logic                pushValid,
  input  aluPkg::aluCommand   pushData,
  input  logic                popReady,
  output aluPkg::aluCommand   popData,
  output logic                full,
  output logic                empty
);
  import aluPkg::*;

  localparam int ptrWidth   = $clog2(`QUEUE_DEPTH);
  localparam int countWidth = $clog2(`QUEUE_DEPTH + 1);

  // Payload storage
  aluCommand             entries [`QUEUE_DEPTH];
  logic [ptrWidth-1:0]   wrPtr;
  logic [ptrWidth-1:0]   rdPtr;
  logic [countWidth-1:0] count;
  logic                  doPush;
  logic                  doPop;

  // Wrap at the last entry
  function automatic logic [ptrWidth-1:0] nextPtr(input logic [ptrWidth-1:0] ptr);
    if (ptr == ptrWidth'(`QUEUE_DEPTH - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign full   = (count == countWidth'(`QUEUE_DEPTH));
  assign empty  = (count == '0);
  // Push on full and pop on empty are dropped
  assign doPush = pushValid && !full;
  assign doPop  = popReady && !empty;

  // Head entry shows the cycle after its write
  assign popData = entries[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
      entries[wrPtr] <= pushData;
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= nextPtr(wrPtr);
      if (doPop)
        rdPtr <= nextPtr(rdPtr);
      // Simultaneous push and pop leaves the count as is
      if (doPush && !doPop)
        count <= count + 1'b1;
      else if (doPop && !doPush)
        count <= count - 1'b1;
    end
  end

endmodule

// File: design/aluExecutor.sv
/* ALU command executor */
`include "alu_macros.svh"

module aluExecutor (
  input  logic                    clk,
  input  logic                    reset,
  input  aluPkg::aluCommand       popData,
  input  logic                    empty,
  input  logic                    resultAck,
  output logic                    popReady,
  output logic                    resultReq,
  output logic [`ALU_WIDTH-1:0]   resultF,
  output logic                    resultCarryOut,
  output logic                    resultEqual
);
  import aluPkg::*;

  // Release phase waits for ack to drop
  typedef enum logic [1:0] {
    idle        = 2'd0,
    present     = 2'd1,
    releaseWait = 2'd2
  } executorState;

  executorState           state;
  aluResult               resultReg;
  logic [`ALU_WIDTH-1:0]  aluF;
  logic                   aluCarryOut;
  logic                   aluEqual;

  // Head command feeds the ALU directly
  wideAlu alu (
    .select   (popData.select),
    .mode     (popData.mode),
    .carryIn  (popData.carryIn),
    .a        (popData.a),
    .b        (popData.b),
    .f        (aluF),
    .carryOut (aluCarryOut),
    .equal    (aluEqual)
  );

  assign popReady = (state == idle) && !empty;
  assign resultReq = (state == present);

  // Result stays put through the whole handshake
  assign resultF        = resultReg.f;
  assign resultCarryOut = resultReg.carryOut;
  assign resultEqual    = resultReg.equal;

  // Capture on the popping edge
  always_ff @(posedge clk)
  begin
    if (popReady)
      resultReg <= '{f: aluF, carryOut: aluCarryOut, equal: aluEqual};
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= idle;
    end
    else
    begin
      case (state)
        idle:
          if (popReady)
            state <= present;
        present:
          if (resultAck)
            state <= releaseWait;
        // Next pop only once ack is low again
        default:
          if (!resultAck)
            state <= idle;
      endcase
    end
  end

endmodule

// File: design/aluTop.sv
/* ALU service top level */
`include "alu_macros.svh"

module aluTop (
  input  logic                    clk,
  input  logic                    reset,
  // Command port
  input  logic                    cmdReq,
  input  aluPkg::aluSelect        cmdSelect,
  input  aluPkg::aluMode          cmdMode,
  input  logic                    cmdCarryIn,
  input  logic [`ALU_WIDTH-1:0]   cmdA,
  input  logic [`ALU_WIDTH-1:0]   cmdB,
  output logic                    cmdAck,
  // Result port
  output logic                    resultReq,
  output logic [`ALU_WIDTH-1:0]   resultF,
  output logic                    resultCarryOut,
  output logic                    resultEqual,
  input  logic                    resultAck
);
  import aluPkg::*;

  logic       pushValid;
  aluCommand  pushData;
  logic       full;
  logic       popReady;
  aluCommand  popData;
  logic       empty;

  requestReceiver receiver (
    .clk        (clk),
    .reset      (reset),
    .cmdReq     (cmdReq),
    .cmdSelect  (cmdSelect),
    .cmdMode    (cmdMode),
    .cmdCarryIn (cmdCarryIn),
    .cmdA       (cmdA),
    .cmdB       (cmdB),
    .full       (full),
    .cmdAck     (cmdAck),
    .pushValid  (pushValid),
    .pushData   (pushData)
  );

  // Commands wait here between the two handshakes
  commandQueue queue (
    .clk       (clk),
    .reset     (reset),
    .pushValid (pushValid),
    .pushData  (pushData),
    .popReady  (popReady),
    .popData   (popData),
    .full      (full),
    .empty     (empty)
  );

  aluExecutor executor (
    .clk            (clk),
    .reset          (reset),
    .popData        (popData),
    .empty          (empty),
    .resultAck      (resultAck),
    .popReady       (popReady),
    .resultReq      (resultReq),
    .resultF        (resultF),
    .resultCarryOut (resultCarryOut),
    .resultEqual    (resultEqual)
  );

endmodule

// File: sim/clockGen.sv
/* Testbench clock and reset */
module clockGen (
  output logic clk,
  output logic reset
);

  // 20-unit period
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held over 8 rising edges, released on a falling edge
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

// File: sim/aluTb.sv
/* ALU service testbench */
`include "alu_macros.svh"

module aluTb;
  import aluPkg::*;

  localparam int waitLimit = 200;
  localparam int randomCount = 20;

  logic                   clk;
  logic                   reset;
  logic                   cmdReq;
  aluSelect               cmdSelect;
  aluMode                 cmdMode;
  logic                   cmdCarryIn;
  logic [`ALU_WIDTH-1:0]  cmdA;
  logic [`ALU_WIDTH-1:0]  cmdB;
  logic                   cmdAck;
  logic                   resultReq;
  logic [`ALU_WIDTH-1:0]  resultF;
  logic                   resultCarryOut;
  logic                   resultEqual;
  logic                   resultAck;

  int seed;
  int checkCount;
  int errorCount;
  int timeoutCount;
  // Sent commands awaiting their results in send order
  aluCommand pending [$];

  clockGen clocks (
    .clk   (clk),
    .reset (reset)
  );

  aluTop UUT (
    .clk            (clk),
    .reset          (reset),
    .cmdReq         (cmdReq),
    .cmdSelect      (cmdSelect),
    .cmdMode        (cmdMode),
    .cmdCarryIn     (cmdCarryIn),
    .cmdA           (cmdA),
    .cmdB           (cmdB),
    .cmdAck         (cmdAck),
    .resultReq      (resultReq),
    .resultF        (resultF),
    .resultCarryOut (resultCarryOut),
    .resultEqual    (resultEqual),
    .resultAck      (resultAck)
  );

  // Zero-extend one operand to the carry width
  function automatic logic [`ALU_WIDTH:0] wide(input logic [`ALU_WIDTH-1:0] x);
    return {1'b0, x};
  endfunction

  // 181 table on active-high data with active-low carry pins
  function automatic aluResult expectedResult(input aluCommand cmd);
    logic [`ALU_WIDTH:0]    total;
    logic [`ALU_WIDTH-1:0]  a;
    logic [`ALU_WIDTH-1:0]  b;
    logic [`ALU_WIDTH-1:0]  ones;
    aluResult               res;
    a = cmd.a;
    b = cmd.b;
    ones = '1;
    if (cmd.mode == modeArith)
    begin
      case (cmd.select)
        4'h0:    total = wide(a);
        4'h1:    total = wide(a | b);
        4'h2:    total = wide(a | ~b);
        4'h3:    total = wide(ones);                   // minus 1
        4'h4:    total = wide(a) + wide(a & ~b);
        4'h5:    total = wide(a | b) + wide(a & ~b);
        4'h6:    total = wide(a) + wide(~b);           // A minus B minus 1
        4'h7:    total = wide(a & ~b) + wide(ones);
        4'h8:    total = wide(a) + wide(a & b);
        4'h9:    total = wide(a) + wide(b);
        4'hA:    total = wide(a | ~b) + wide(a & b);
        4'hB:    total = wide(a & b) + wide(ones);
        4'hC:    total = wide(a) + wide(a);
        4'hD:    total = wide(a | b) + wide(a);
        4'hE:    total = wide(a | ~b) + wide(a);
        default: total = wide(a) + wide(ones);        // A minus 1
      endcase
      // Low carry in adds one
      if (!cmd.carryIn)
        total = total + {{`ALU_WIDTH{1'b0}}, 1'b1};
      res.f = total[`ALU_WIDTH-1:0];
      res.carryOut = ~total[`ALU_WIDTH];
    end
    else
    begin
      case (cmd.select)
        4'h0:    res.f = ~a;
        4'h1:    res.f = ~(a | b);
        4'h2:    res.f = ~a & b;
        4'h3:    res.f = '0;
        4'h4:    res.f = ~(a & b);
        4'h5:    res.f = ~b;
        4'h6:    res.f = a ^ b;
        4'h7:    res.f = a & ~b;
        4'h8:    res.f = ~a | b;
        4'h9:    res.f = ~(a ^ b);
        4'hA:    res.f = b;
        4'hB:    res.f = a & b;
        4'hC:    res.f = ones;
        4'hD:    res.f = a | ~b;
        4'hE:    res.f = a | b;
        default: res.f = a;
      endcase
      // Not compared in logic mode
      res.carryOut = 1'b1;
    end
    res.equal = &res.f;
    return res;
  endfunction

  function automatic aluCommand makeCommand(input aluSelect sel, input aluMode mode,
                                            input logic carryIn,
                                            input logic [`ALU_WIDTH-1:0] a,
                                            input logic [`ALU_WIDTH-1:0] b);
    aluCommand cmd;
    cmd.select = sel;
    cmd.mode = mode;
    cmd.carryIn = carryIn;
    cmd.a = a;
    cmd.b = b;
    return cmd;
  endfunction

  // Truth-table nibble on A=1100 and B=1010 names exactly one logic select
  function automatic aluSelect decodeLogicSelect(input logic [3:0] nibble);
    aluResult probe;
    aluSelect found;
    found = '0;
    for (int s = 0; s < 16; s++)
    begin
      probe = expectedResult(makeCommand(aluSelect'(s), modeLogic, 1'b1,
                                         16'hCCCC, 16'hAAAA));
      if (probe.f[3:0] == nibble)
        found = aluSelect'(s);
    end
    return found;
  endfunction

  task automatic finishRun();
    $display("Checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic abortRun(input string what);
    $display("%0t %s", $time, what);
    timeoutCount++;
    finishRun();
  endtask

  task automatic compareResult(input aluResult actual, input aluResult expected,
                               input logic checkCarry);
    checkCount++;
    if (actual.f !== expected.f)
    begin
      errorCount++;
      $display("[ERROR] %0t resultF expected %h got %h", $time, expected.f, actual.f);
    end
    if (checkCarry && actual.carryOut !== expected.carryOut)
    begin
      errorCount++;
      $display("[ERROR] %0t resultCarryOut expected %b got %b", $time,
               expected.carryOut, actual.carryOut);
    end
    if (actual.equal !== expected.equal)
    begin
      errorCount++;
      $display("[ERROR] %0t resultEqual expected %b got %b", $time,
               expected.equal, actual.equal);
    end
  endtask

  task automatic compareSelect(input aluSelect actual, input aluSelect expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[ERROR] %0t select expected %h got %h", $time, expected, actual);
    end
  endtask

  task automatic compareBit(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
    end
  endtask

  // Waits step on falling edges where outputs are settled
  task automatic waitCmdAck(input logic level);
    int cycles;
    cycles = 0;
    while (cmdAck !== level && cycles < waitLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (cmdAck !== level)
      abortRun($sformatf("Timed out waiting for cmdAck to go %0b", level));
  endtask

  task automatic waitResultReq(input logic level);
    int cycles;
    cycles = 0;
    while (resultReq !== level && cycles < waitLimit)
    begin
      @(negedge clk);
      cycles++;
    end
    if (resultReq !== level)
      abortRun($sformatf("Timed out waiting for resultReq to go %0b", level));
  endtask

  // Raises the request without waiting for the ack
  task automatic startCommand(input aluCommand cmd);
    waitCmdAck(1'b0);
    cmdSelect = cmd.select;
    cmdMode = cmd.mode;
    cmdCarryIn = cmd.carryIn;
    cmdA = cmd.a;
    cmdB = cmd.b;
    cmdReq = 1'b1;
    pending.push_back(cmd);
  endtask

  task automatic finishCommand();
    waitCmdAck(1'b1);
    cmdReq = 1'b0;
  endtask

  task automatic sendCommand(input aluCommand cmd);
    startCommand(cmd);
    finishCommand();
  endtask

  // Delay stretches the time before ack
  task automatic takeResult(output aluResult got, input int delay);
    waitResultReq(1'b1);
    repeat (delay) @(negedge clk);
    got.f = resultF;
    got.carryOut = resultCarryOut;
    got.equal = resultEqual;
    resultAck = 1'b1;
    waitResultReq(1'b0);
    resultAck = 1'b0;
  endtask

  // Next result against the oldest pending command
  task automatic verifyNext(input int delay, output aluResult got, output aluCommand cmd);
    takeResult(got, delay);
    if (pending.size() == 0)
    begin
      errorCount++;
      $display("%0t A result arrived with no command outstanding", $time);
      cmd = '0;
    end
    else
    begin
      cmd = pending.pop_front();
      compareResult(got, expectedResult(cmd), cmd.mode == modeArith);
    end
  endtask

  task automatic resetPhase();
    int cycles;
    logic released;
    cycles = 0;
    released = 1'b0;
    while (!released && cycles < waitLimit)
    begin
      @(negedge clk);
      compareBit("cmdAck", cmdAck, 1'b0);
      compareBit("resultReq", resultReq, 1'b0);
      // Reset only moves on falling edges
      @(posedge clk);
      released = (reset === 1'b0);
      cycles++;
    end
    if (!released)
      abortRun("Reset was never released");
    repeat (2)
    begin
      @(negedge clk);
      compareBit("cmdAck", cmdAck, 1'b0);
      compareBit("resultReq", resultReq, 1'b0);
    end
  endtask

  // Carries across slice boundaries and out of the word
  task automatic addSubtractCases();
    aluCommand cases [$];
    aluResult got;
    aluCommand cmd;
    cases.push_back(makeCommand(selAdd, modeArith, 1'b1, 16'h00FF, 16'h0001));
    cases.push_back(makeCommand(selAdd, modeArith, 1'b0, 16'h00FF, 16'h0001));
    cases.push_back(makeCommand(selAdd, modeArith, 1'b0, 16'hFFFF, 16'h0001));
    cases.push_back(makeCommand(selAdd, modeArith, 1'b0, 16'hFFFF, 16'h0000));
    cases.push_back(makeCommand(selAdd, modeArith, 1'b1, 16'h0FFF, 16'hF001));
    cases.push_back(makeCommand(selAdd, modeArith, 1'b1, 16'h7FF0, 16'h0010));
    cases.push_back(makeCommand(selSubtract, modeArith, 1'b0, 16'h1000, 16'h0001));
    cases.push_back(makeCommand(selSubtract, modeArith, 1'b0, 16'h0000, 16'h0001));
    cases.push_back(makeCommand(selSubtract, modeArith, 1'b0, 16'h8000, 16'h7FFF));
    cases.push_back(makeCommand(selShiftLeft, modeArith, 1'b1, 16'h8421, 16'h0000));
    cases.push_back(makeCommand(selMinusOne, modeArith, 1'b1, 16'h1234, 16'h5678));
    foreach (cases[i])
    begin
      sendCommand(cases[i]);
      verifyNext(0, got, cmd);
    end
  endtask

  // A=1100 and B=1010 per nibble expose each function's truth table
  task automatic logicSweep();
    aluResult got;
    aluCommand cmd;
    for (int s = 0; s < 16; s++)
    begin
      sendCommand(makeCommand(aluSelect'(s), modeLogic, 1'b1, 16'hCCCC, 16'hAAAA));
      verifyNext(0, got, cmd);
      compareSelect(decodeLogicSelect(got.f[3:0]), cmd.select);
      // Only the constant-one select gives all ones on these operands
      compareBit("resultEqual", got.equal, s == 4'hC);
      sendCommand(makeCommand(aluSelect'(s), modeLogic, s[0], 16'h1234, 16'hFEDC));
      verifyNext(1, got, cmd);
    end
  endtask

  // A minus B minus 1 is all ones only when A equals B
  task automatic subtractCompare();
    logic [`ALU_WIDTH-1:0] pairA [6];
    logic [`ALU_WIDTH-1:0] pairB [6];
    aluResult got;
    aluCommand cmd;
    pairA = '{16'h1234, 16'h1234, 16'h8000, 16'h0000, 16'hFFFF, 16'h0000};
    pairB = '{16'h1234, 16'h1235, 16'h7FFF, 16'h0000, 16'h0000, 16'hFFFF};
    for (int i = 0; i < 6; i++)
    begin
      sendCommand(makeCommand(selSubtract, modeArith, 1'b1, pairA[i], pairB[i]));
      verifyNext(0, got, cmd);
      compareBit("resultEqual", got.equal, pairA[i] == pairB[i]);
      // Carry out low means A above B
      compareBit("resultCarryOut", got.carryOut, !(pairA[i] > pairB[i]));
    end
  endtask

  // Sender and receiver run side by side
  task automatic randomMix();
    aluCommand cmds [randomCount];
    int delays [randomCount];
    logic [31:0] r;
    for (int i = 0; i < randomCount; i++)
    begin
      r = $random(seed);
      cmds[i].select = r[3:0];
      cmds[i].mode = r[4] ? modeLogic : modeArith;
      cmds[i].carryIn = r[5];
      delays[i] = int'(r[7:6]);
      r = $random(seed);
      cmds[i].a = r[`ALU_WIDTH-1:0];
      r = $random(seed);
      cmds[i].b = r[`ALU_WIDTH-1:0];
    end
    fork
      for (int i = 0; i < randomCount; i++)
        sendCommand(cmds[i]);
      for (int i = 0; i < randomCount; i++)
      begin
        aluResult got;
        aluCommand cmd;
        verifyNext(delays[i], got, cmd);
      end
    join
  endtask

  // Queue plus executor hold QUEUE_DEPTH+1 so the next request must wait
  task automatic backPressure();
    logic [`ALU_WIDTH-1:0] opA;
    aluResult got;
    aluCommand cmd;
    opA = 16'h1000;
    for (int i = 0; i <= `QUEUE_DEPTH; i++)
    begin
      opA = opA + 16'h0111;
      sendCommand(makeCommand(i[0] ? selPassA : selAdd, i[0] ? modeLogic : modeArith,
                              1'b1, opA, 16'h0F0F));
    end
    startCommand(makeCommand(selAdd, modeArith, 1'b0, 16'hBEEF, 16'h0101));
    repeat (2 * `QUEUE_DEPTH)
    begin
      @(negedge clk);
      compareBit("cmdAck", cmdAck, 1'b0);
      compareBit("resultReq", resultReq, 1'b1);
    end
    // One drained result frees a slot for the stalled request
    verifyNext(0, got, cmd);
    finishCommand();
    for (int i = 0; i <= `QUEUE_DEPTH; i++)
      verifyNext(0, got, cmd);
  endtask

  initial
  begin
    seed = 32'h391c;
    checkCount = 0;
    errorCount = 0;
    timeoutCount = 0;
    cmdReq = 1'b0;
    cmdSelect = '0;
    cmdMode = modeArith;
    cmdCarryIn = 1'b1;
    cmdA = '0;
    cmdB = '0;
    resultAck = 1'b0;

    resetPhase();
    addSubtractCases();
    logicSweep();
    subtractCompare();
    randomMix();
    backPressure();
    if (pending.size() != 0)
    begin
      errorCount++;
      $display("%0t No result came back for %0d commands", $time, pending.size());
    end
    finishRun();
  end

endmodule

// File: sources.f
+incdir+design
design/aluPkg.sv
design/aluSlice.sv
design/carryLookahead.sv
design/wideAlu.sv
design/requestReceiver.sv
design/commandQueue.sv
design/aluExecutor.sv
design/aluTop.sv
sim/clockGen.sv
sim/aluTb.sv

// File: run.sh
#!/bin/sh
# Build the ALU testbench with Verilator, run it, then scan the log
verilator --binary --timing --top-module aluTb -f sources.f -o aluSim > build.log 2>&1 \
  || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/aluSim > sim.log 2>&1
cat sim.log
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0
